//--- src/gpio_pkg.sv
// Shared definitions for the SPI GPIO expander
// Widths, register map and SPI slave enums

package gpio_pkg;

  // Frame layout, MSB first: opcode, address, data
  localparam int ADDR_W  = 7;                   // Register address bits
  localparam int DATA_W  = 8;                   // Register byte
  localparam int FRAME_W = 1 + ADDR_W + DATA_W; // Full SPI frame, 16 bits

  // Register map
  localparam logic [ADDR_W-1:0] PORT0_ADDR = 7'h01; // gpio[7:0], read/write
  localparam logic [ADDR_W-1:0] PORT1_ADDR = 7'h02; // gpio[15:8], read/write
  localparam logic [ADDR_W-1:0] PORT2_ADDR = 7'h03; // gpio[23:16], read only

  // First bit of every frame
  typedef enum logic {
    OP_WRITE = 1'b0, // Data byte goes into the addressed register
    OP_READ  = 1'b1  // Addressed register shifts out on so
  } spi_op_e;

  // Slave frame tracking
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0, // Waiting for chip select to fall
    ST_HEADER = 2'd1, // Opcode and address bits
    ST_DATA   = 2'd2  // Data byte bits
  } spi_state_e;

endpackage

//--- src/spi_slave.sv
`timescale 1ns/1ps
// SPI slave for the GPIO expander
// Pin synchronizers, frame deserializer and readback serializer

module spi_slave (
  input  logic                          fx2_clk,  // System clock
  input  logic                          arst_n,   // Async reset, active low
  input  logic                          sck,      // SPI clock from host, idles low
  input  logic                          si,       // Serial in, MSB first
  inout  wire                           so,       // Serial out, high-Z when deselected
  input  logic                          cs_n,     // Chip select, frames one transfer
  output logic [gpio_pkg::ADDR_W-1:0]   reg_addr, // Address from the frame header
  output logic [gpio_pkg::DATA_W-1:0]   wr_data,  // Byte of the last write frame
  output logic                          wr_stb,   // One-cycle write strobe
  input  logic [gpio_pkg::DATA_W-1:0]   rd_data   // Readback for reg_addr
);

  localparam int CNT_W = $clog2(gpio_pkg::FRAME_W);
  // Bit index of the last header bit and of the last frame bit
  localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(gpio_pkg::FRAME_W - gpio_pkg::DATA_W - 1);
  localparam logic [CNT_W-1:0] FRM_LAST = CNT_W'(gpio_pkg::FRAME_W - 1);

  logic sck_m, sck_s, sck_d;  // sck sync pair plus edge history
  logic si_m, si_s;           // si sync pair
  logic cs_m, cs_s, cs_d;     // cs_n sync pair plus edge history
  logic sck_rise, sck_fall, cs_fall;

  gpio_pkg::spi_state_e state;
  gpio_pkg::spi_op_e    op;   // Opcode of the current frame
  logic [CNT_W-1:0]     bit_cnt;
  logic                 hdr_end, frm_end;
  logic                 hdr_done; // Cycle after the header, rd_data is valid here
  logic                 so_oe;    // Read frame in progress

  logic [gpio_pkg::DATA_W-1:0] rx_sr;   // Incoming bits
  logic [gpio_pkg::DATA_W-1:0] rx_byte; // Byte completed by the current edge
  logic [gpio_pkg::DATA_W-1:0] tx_sr;   // Readback byte being shifted out
  logic                        so_q;

  // Two-flop synchronizers, one more stage for edge detection
  always_ff @(posedge fx2_clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_m <= 1'b0;
      sck_s <= 1'b0;
      sck_d <= 1'b0;
      si_m  <= 1'b0;
      si_s  <= 1'b0;
      cs_m  <= 1'b1;  // Deselected
      cs_s  <= 1'b1;
      cs_d  <= 1'b1;
    end else begin
      sck_m <= sck;
      sck_s <= sck_m;
      sck_d <= sck_s;
      si_m  <= si;
      si_s  <= si_m;
      cs_m  <= cs_n;
      cs_s  <= cs_m;
      cs_d  <= cs_s;
    end
  end

  assign sck_rise = sck_s & ~sck_d;  // Sample si here
  assign sck_fall = ~sck_s & sck_d;  // Update so here
  assign cs_fall  = ~cs_s & cs_d;    // Start of a frame

  assign rx_byte = {rx_sr[gpio_pkg::DATA_W-2:0], si_s};

  // Last header bit and last frame bit, only while still selected
  assign hdr_end = !cs_s && (state == gpio_pkg::ST_HEADER) && sck_rise && (bit_cnt == HDR_LAST);
  assign frm_end = !cs_s && (state == gpio_pkg::ST_DATA) && sck_rise && (bit_cnt == FRM_LAST);

  // Frame FSM
  always_ff @(posedge fx2_clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= gpio_pkg::ST_IDLE;
      op       <= gpio_pkg::OP_WRITE;
      bit_cnt  <= '0;
      hdr_done <= 1'b0;
      wr_stb   <= 1'b0;
      so_oe    <= 1'b0;
    end else begin
      hdr_done <= hdr_end;
      wr_stb   <= frm_end && (op == gpio_pkg::OP_WRITE);
      if (cs_s) begin
        // Deselect drops whatever is left of a short frame
        state <= gpio_pkg::ST_IDLE;
        so_oe <= 1'b0;
      end else begin
        case (state)
          gpio_pkg::ST_IDLE: begin
            if (cs_fall) begin
              state   <= gpio_pkg::ST_HEADER;
              bit_cnt <= '0;
            end
          end
          gpio_pkg::ST_HEADER: begin
            if (sck_rise) bit_cnt <= bit_cnt + 1'b1;
            if (hdr_end) begin
              op    <= gpio_pkg::spi_op_e'(rx_byte[gpio_pkg::DATA_W-1]); // MSB is the opcode
              so_oe <= (rx_byte[gpio_pkg::DATA_W-1] == gpio_pkg::OP_READ);
              state <= gpio_pkg::ST_DATA;
            end
          end
          gpio_pkg::ST_DATA: begin
            if (sck_rise) bit_cnt <= bit_cnt + 1'b1;
            if (frm_end) state <= gpio_pkg::ST_IDLE; // Wait for the next cs_n fall
          end
          default: state <= gpio_pkg::ST_IDLE;
        endcase
      end
    end
  end

  // Shift registers and frame fields
  always_ff @(posedge fx2_clk) begin
    if (sck_rise) rx_sr <= rx_byte;
    if (hdr_end) reg_addr <= rx_byte[gpio_pkg::ADDR_W-1:0];     // Also the readback address
    if (frm_end && (op == gpio_pkg::OP_WRITE)) wr_data <= rx_byte; // Held until the next write
    if (hdr_done) begin
      tx_sr <= rd_data;  // Register value selected by the new address
    end else if ((state == gpio_pkg::ST_DATA) && sck_fall) begin
      so_q  <= tx_sr[gpio_pkg::DATA_W-1];
      tx_sr <= {tx_sr[gpio_pkg::DATA_W-2:0], 1'b0};
    end
  end

  // Driven only during read frames and only while the pin is selected
  assign so = (so_oe && !cs_n) ? so_q : 1'bz;

endmodule

//--- src/port_register.sv
`timescale 1ns/1ps
// Addressed output register with change detect
// One instance per output port

module port_register #(
  parameter logic [gpio_pkg::ADDR_W-1:0] REG_ADDR = gpio_pkg::PORT0_ADDR, // Own address
  parameter int                          PORT_W   = gpio_pkg::DATA_W      // Port width
) (
  input  logic                        fx2_clk,  // System clock
  input  logic                        arst_n,   // Async reset, active low
  input  logic                        wr_stb,   // Write strobe from the SPI slave
  input  logic [gpio_pkg::ADDR_W-1:0] reg_addr, // Target address of the write
  input  logic [PORT_W-1:0]           wr_data,  // Byte to load
  output logic [PORT_W-1:0]           value,    // Current port value
  output logic                        changed   // One-cycle pulse on a new value
);

  logic hit;  // Write aimed at this register

  assign hit = wr_stb && (reg_addr == REG_ADDR);

  always_ff @(posedge fx2_clk or negedge arst_n) begin
    if (!arst_n) begin
      value   <= '0;
      changed <= 1'b0;
    end else begin
      changed <= 1'b0;  // Pulse, never held
      if (hit) begin
        value   <= wr_data;
        // Rewriting the same byte is silent
        changed <= (wr_data != value);
      end
    end
  end

endmodule

//--- src/gpio_pins.sv
`timescale 1ns/1ps
// GPIO pin block
// Output port drivers, input port synchronizer, readback mux

module gpio_pins #(
  parameter int PORT_W = gpio_pkg::DATA_W  // Width of each port
) (
  input  logic                        fx2_clk,  // System clock
  input  logic                        arst_n,   // Async reset, active low
  input  logic [PORT_W-1:0]           port0,    // Port 0 register value
  input  logic [PORT_W-1:0]           port1,    // Port 1 register value
  inout  wire  [23:0]                 gpio,     // Board GPIO lines
  input  logic [gpio_pkg::ADDR_W-1:0] rd_addr,  // Readback address from the SPI slave
  output logic [gpio_pkg::DATA_W-1:0] rd_data   // Readback byte
);

  logic [PORT_W-1:0] in_meta;  // First sync stage for port 2
  logic [PORT_W-1:0] in_sync;  // Port 2 sample, two cycles behind the pins

  // Fixed directions: ports 0 and 1 out, port 2 in
  assign gpio[PORT_W-1:0]        = port0;
  assign gpio[2*PORT_W-1:PORT_W] = port1;
  assign gpio[23:2*PORT_W]       = 'z;   // Left to the board

  always_ff @(posedge fx2_clk or negedge arst_n) begin
    if (!arst_n) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio[23:2*PORT_W];
      in_sync <= in_meta;
    end
  end

  // Readback select
  always_comb begin
    case (rd_addr)
      gpio_pkg::PORT0_ADDR: rd_data = port0;
      gpio_pkg::PORT1_ADDR: rd_data = port1;
      gpio_pkg::PORT2_ADDR: rd_data = in_sync;
      default:              rd_data = '0;     // Unmapped reads as zero
    endcase
  end

endmodule

//--- src/gpio_control.sv
`timescale 1ns/1ps
// Top level of the SPI GPIO expander
// SPI slave, two output port registers and the pin block

module gpio_control #(
  parameter int PORT_W = gpio_pkg::DATA_W  // Width of each GPIO port
) (
  input  logic       fx2_clk,      // Master system clock
  input  logic       arst_n,       // Async reset, active low
  input  logic       sck,          // SPI clock from the host
  input  logic       si,           // SPI serial in
  inout  wire        so,           // SPI serial out
  input  logic       cs_n,         // SPI chip select
  inout  wire [23:0] gpio,         // Board GPIO lines
  output logic [1:0] port_changed  // Change pulses for ports 1 and 0
);

  // SPI slave to register side
  logic [gpio_pkg::ADDR_W-1:0] reg_addr;
  logic [gpio_pkg::DATA_W-1:0] wr_data;
  logic                        wr_stb;
  logic [gpio_pkg::DATA_W-1:0] rd_data;  // Back from the pin block

  // Output port values
  logic [PORT_W-1:0] port0_value;
  logic [PORT_W-1:0] port1_value;

  spi_slave u_spi_slave (
    .fx2_clk  (fx2_clk),
    .arst_n   (arst_n),
    .sck      (sck),
    .si       (si),
    .so       (so),
    .cs_n     (cs_n),
    .reg_addr (reg_addr),
    .wr_data  (wr_data),
    .wr_stb   (wr_stb),
    .rd_data  (rd_data)
  );

  // gpio[7:0], address 0x01
  port_register #(
    .REG_ADDR (gpio_pkg::PORT0_ADDR),
    .PORT_W   (PORT_W)
  ) u_port0 (
    .fx2_clk  (fx2_clk),
    .arst_n   (arst_n),
    .wr_stb   (wr_stb),
    .reg_addr (reg_addr),
    .wr_data  (wr_data),
    .value    (port0_value),
    .changed  (port_changed[0])
  );

  // gpio[15:8], address 0x02
  port_register #(
    .REG_ADDR (gpio_pkg::PORT1_ADDR),
    .PORT_W   (PORT_W)
  ) u_port1 (
    .fx2_clk  (fx2_clk),
    .arst_n   (arst_n),
    .wr_stb   (wr_stb),
    .reg_addr (reg_addr),
    .wr_data  (wr_data),
    .value    (port1_value),
    .changed  (port_changed[1])
  );

  // Pins and readback, port 2 is input only
  gpio_pins #(
    .PORT_W (PORT_W)
  ) u_gpio_pins (
    .fx2_clk (fx2_clk),
    .arst_n  (arst_n),
    .port0   (port0_value),
    .port1   (port1_value),
    .gpio    (gpio),
    .rd_addr (reg_addr),
    .rd_data (rd_data)
  );

endmodule

//--- bench/gpio_control_tb.sv
`timescale 1ns/1ps
// Testbench for the SPI GPIO expander
// Golden file transactions, seeded random writes, pin, readback and pulse checks

module gpio_control_tb;

  localparam int CLK_PERIOD = 20;    // fx2_clk period in ns
  localparam int HALF       = 4;     // fx2_clk cycles per sck half-period
  localparam int FRAME_CYC  = 160;   // Watchdog budget per frame in cycles
  localparam int NUM_RAND   = 24;    // Random write frames after the golden ones
  localparam int MARGIN_NS  = 4000;  // Reset and slack

  logic        fx2_clk;
  logic        arst_n;
  logic        sck;
  logic        si;
  logic        cs_n;
  logic [7:0]  gpio_in;        // Board side of port 2
  logic [1:0]  port_changed;
  wire         so;
  wire  [23:0] gpio;

  // One golden entry per data line
  logic [7:0]  t_op[$];
  logic [6:0]  t_addr[$];
  logic [7:0]  t_data[$];
  logic [7:0]  t_gin[$];
  logic [15:0] t_exp[$];
  logic [1:0]  t_chg[$];

  int          n_lines = 0;
  bit          loaded = 1'b0;    // Watchdog starts once the file is in
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          bad_cnt = 0;
  int          chg_cnt[2] = '{0, 0};  // port_changed pulses seen so far
  integer      seed;
  logic [7:0]  model0;          // Expected port 0 value
  logic [7:0]  model1;          // Expected port 1 value

  gpio_control #(
    .PORT_W (gpio_pkg::DATA_W)
  ) dut (
    .fx2_clk      (fx2_clk),
    .arst_n       (arst_n),
    .sck          (sck),
    .si           (si),
    .so           (so),
    .cs_n         (cs_n),
    .gpio         (gpio),
    .port_changed (port_changed)
  );

  assign gpio[23:16] = gpio_in;  // Input port driven by the board
  pullup (so);                   // Released so reads high

  initial begin
    fx2_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fx2_clk = ~fx2_clk;
  end

  // Counts change pulses at mid-cycle
  always @(negedge fx2_clk) begin
    if (port_changed[0]) chg_cnt[0]++;
    if (port_changed[1]) chg_cnt[1]++;
  end

  // Skips comment and blank lines of the golden file
  task automatic load_golden(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  f_op;
    logic [6:0]  f_addr;
    logic [7:0]  f_data;
    logic [7:0]  f_gin;
    logic [15:0] f_exp;
    logic [1:0]  f_chg;
    ok = 1'b0;
    fd = $fopen("bench/gpio_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/gpio_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_data, f_gin, f_exp, f_chg);
          if (n == 6) begin
            t_op.push_back(f_op);
            t_addr.push_back(f_addr);
            t_data.push_back(f_data);
            t_gin.push_back(f_gin);
            t_exp.push_back(f_exp);
            t_chg.push_back(f_chg);
          end
        end
      end
      $fclose(fd);
      n_lines = t_op.size();
      ok = (n_lines > 0);
      if (!ok) $display("golden file holds no transactions");
    end
    loaded = 1'b1;
  endtask

  // SPI master shifts MSB first and samples so as sck rises
  task automatic spi_frame(input logic [15:0] frame, input int nbits,
                           output logic [7:0] so_byte);
    int i;
    so_byte = 8'h00;
    @(negedge fx2_clk);
    cs_n = 1'b0;
    for (i = 0; i < nbits; i++) begin
      si = frame[15-i];
      repeat (HALF) @(negedge fx2_clk);
      if (i >= 8) so_byte = {so_byte[6:0], so};  // Data byte only
      sck = 1'b1;
      repeat (HALF) @(negedge fx2_clk);
      sck = 1'b0;
    end
    repeat (HALF) @(negedge fx2_clk);
    cs_n = 1'b1;
    si   = 1'b0;
    repeat (6) @(negedge fx2_clk);  // Settle time before checks
  endtask

  // One line per finished test
  task automatic log_result(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      bad_cnt++;
      $display("test %0d %s: FAIL", test_cnt, name);
    end
  endtask

  task automatic check_reset();
    int err0;
    err0 = err_cnt;
    repeat (2) @(negedge fx2_clk);
    if (gpio[15:0] !== 16'h0000) begin
      $display("error gpio[15:0] expected 0x0000 got 0x%04h", gpio[15:0]);
      err_cnt++;
    end
    if (so !== 1'b1) begin
      $display("so is driven after reset while chip select is high");
      err_cnt++;
    end
    if (port_changed !== 2'b00) begin
      $display("error port_changed expected 0x0 got 0x%01h", port_changed);
      err_cnt++;
    end
    if (chg_cnt[0] != 0 || chg_cnt[1] != 0) begin
      $display("a port_changed pulse fired during or right after reset");
      err_cnt++;
    end
    log_result("reset state", err0);
  endtask

  // Op 0 is a write, 1 a read and 2 a write cut off after 10 bits
  task automatic run_line(input int idx);
    logic [7:0]  rd_byte;
    logic [15:0] frame;
    int          nbits;
    int          c0;
    int          c1;
    int          err0;
    string       kind;
    err0    = err_cnt;
    gpio_in = t_gin[idx];
    frame   = {t_op[idx][0], t_addr[idx], t_data[idx]};
    nbits   = (t_op[idx] == 8'h02) ? 10 : 16;
    kind    = (t_op[idx] == 8'h01) ? "read" : (t_op[idx] == 8'h02) ? "aborted write" : "write";
    c0      = chg_cnt[0];
    c1      = chg_cnt[1];
    spi_frame(frame, nbits, rd_byte);
    if (t_op[idx] == 8'h01) begin
      if (rd_byte !== t_exp[idx][7:0]) begin
        $display("error so readback expected 0x%02h got 0x%02h", t_exp[idx][7:0], rd_byte);
        err_cnt++;
      end
      if (gpio[15:0] !== {model1, model0}) begin  // Reads leave the ports alone
        $display("error gpio[15:0] expected 0x%04h got 0x%04h", {model1, model0}, gpio[15:0]);
        err_cnt++;
      end
    end else begin
      if (gpio[15:0] !== t_exp[idx]) begin
        $display("error gpio[15:0] expected 0x%04h got 0x%04h", t_exp[idx], gpio[15:0]);
        err_cnt++;
      end
      model0 = t_exp[idx][7:0];
      model1 = t_exp[idx][15:8];
    end
    if (chg_cnt[0] - c0 != int'(t_chg[idx][0])) begin
      $display("error port_changed[0] pulses expected 0x%0h got 0x%0h",
               t_chg[idx][0], chg_cnt[0] - c0);
      err_cnt++;
    end
    if (chg_cnt[1] - c1 != int'(t_chg[idx][1])) begin
      $display("error port_changed[1] pulses expected 0x%0h got 0x%0h",
               t_chg[idx][1], chg_cnt[1] - c1);
      err_cnt++;
    end
    if (so !== 1'b1) begin
      $display("so is still driven after chip select went high");
      err_cnt++;
    end
    log_result($sformatf("golden %0d %s addr 0x%02h", idx + 1, kind, t_addr[idx]), err0);
  endtask

  // Random write checked against the register map model
  task automatic run_random(input int k);
    integer     r;
    logic [6:0] addr;
    logic [7:0] data;
    logic [7:0] rd_byte;
    logic [1:0] exp_chg;
    int         c0;
    int         c1;
    int         err0;
    err0    = err_cnt;
    r       = $random(seed);
    addr    = r[0] ? {4'h0, r[3:1]} : r[14:8];  // Half near the register map
    data    = r[23:16];
    gpio_in = r[31:24];
    exp_chg = 2'b00;
    if (addr == 7'h01) begin         // Port 0
      exp_chg[0] = (data != model0);
      model0     = data;
    end else if (addr == 7'h02) begin  // Port 1
      exp_chg[1] = (data != model1);
      model1     = data;
    end                                // Port 2 and unmapped ignore writes
    c0 = chg_cnt[0];
    c1 = chg_cnt[1];
    spi_frame({1'b0, addr, data}, 16, rd_byte);
    if (rd_byte !== 8'hff) begin  // Write frames leave so released
      $display("error so expected 0xff got 0x%02h", rd_byte);
      err_cnt++;
    end
    if (gpio[15:0] !== {model1, model0}) begin
      $display("error gpio[15:0] expected 0x%04h got 0x%04h", {model1, model0}, gpio[15:0]);
      err_cnt++;
    end
    if (chg_cnt[0] - c0 != int'(exp_chg[0])) begin
      $display("error port_changed[0] pulses expected 0x%0h got 0x%0h", exp_chg[0],
               chg_cnt[0] - c0);
      err_cnt++;
    end
    if (chg_cnt[1] - c1 != int'(exp_chg[1])) begin
      $display("error port_changed[1] pulses expected 0x%0h got 0x%0h", exp_chg[1],
               chg_cnt[1] - c1);
      err_cnt++;
    end
    log_result($sformatf("random %0d write addr 0x%02h data 0x%02h", k + 1, addr, data), err0);
  endtask

  initial begin : main
    bit ok;
    int i;
    arst_n  = 1'b0;
    sck     = 1'b0;  // SPI clock idles low
    si      = 1'b0;
    cs_n    = 1'b1;
    gpio_in = 8'h00;
    seed    = 69;
    model0  = 8'h00;
    model1  = 8'h00;
    load_golden(ok);
    repeat (5) @(negedge fx2_clk);
    arst_n = 1'b1;
    if (ok) begin
      check_reset();
      for (i = 0; i < n_lines; i++) run_line(i);
      for (i = 0; i < NUM_RAND; i++) run_random(i);
    end
    $display("summary: %0d tests run, %0d ok, %0d with errors, %0d errors",
             test_cnt, test_cnt - bad_cnt, bad_cnt, err_cnt);
    if (ok && err_cnt == 0 && bad_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the number of frames
  initial begin : watchdog
    longint limit;
    wait (loaded);
    limit = longint'(n_lines + NUM_RAND + 1) * FRAME_CYC * CLK_PERIOD + MARGIN_NS;
    #(limit);
    $display("timeout after %0d ns, the run did not finish", limit);
    $display("tests failed");
    $finish;
  end

endmodule

//--- gpio_control.f
src/gpio_pkg.sv
src/spi_slave.sv
src/port_register.sv
src/gpio_pins.sv
src/gpio_control.sv
bench/gpio_control_tb.sv

//--- Makefile
# Verilator build and run for the SPI GPIO expander
# Any variable can be overridden on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= gpio_control_tb
FLIST     ?= gpio_control.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
GOLDEN    ?= bench/gpio_golden.txt
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= all tests passed
FAIL_MSG  ?= tests failed

SRCS := src/gpio_pkg.sv src/spi_slave.sv src/port_register.sv \
        src/gpio_pins.sv src/gpio_control.sv bench/gpio_control_tb.sv
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(GOLDEN)
	$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation log clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/gpio_golden.txt
# op addr data gpio_in expect chg, all hex; op 0 write, 1 read, 2 write cut after 10 bits
# expect is gpio[15:0] after a write or the so byte of a read; chg bit n is a port n pulse
0 01 5a 00 005a 1
1 01 00 00 5a 0
0 02 c3 00 c35a 2
1 02 00 00 c3 0
# Same values again, no pulses
0 01 5a 00 c35a 0
0 02 c3 00 c35a 0
0 01 a5 00 c3a5 1
# Input port readback
1 03 00 3c 3c 0
1 03 00 e7 e7 0
# Writes that must be ignored
0 03 ff 81 c3a5 0
0 00 11 00 c3a5 0
0 04 22 00 c3a5 0
0 7f 33 00 c3a5 0
# Unmapped reads return zero
1 00 00 00 00 0
1 04 00 00 00 0
1 7f 00 55 00 0
# Frames cut short, then a full one
2 01 ff 00 c3a5 0
2 02 00 00 c3a5 0
0 02 3c 00 3ca5 2
1 02 00 00 3c 0
0 01 00 00 3c00 1
1 01 00 00 00 0
0 02 ff 00 ff00 2
0 01 ff 00 ffff 1
1 01 00 00 ff 0
1 02 00 00 ff 0
1 03 00 00 00 0
1 03 00 ff ff 0
0 01 ff 00 ffff 0
0 02 80 00 80ff 2
0 01 01 00 8001 1
1 03 00 a5 a5 0
0 03 00 a5 8001 0
1 01 00 a5 01 0
1 02 00 a5 80 0
2 02 7f 00 8001 0
1 02 00 00 80 0
0 02 00 00 0001 2
0 01 00 00 0000 1
1 7e 00 00 00 0
